//--- files.f
common/icache_pkg.sv
hw/boot_rom.sv
hw/icache/icache_array.sv
hw/icache/icache_refill_ctrl.sv
hw/icache/icache_cfg_regs.sv
hw/icache_top.sv
test/tb_clkgen.sv
test/icache_assertions.sv
test/icache_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing --assert -Wall
TOP = icache_tb
FILELIST = files.f
BUILD_DIR = obj_dir
LOG = sim.log
PASS_MSG = Everything OK
FAIL_MSG = Something failed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation did not complete"; exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- test/icache_tb.sv
// Instruction cache refill testbench
// Bus memory model with random wait states, reference model for the
// fetched words, and a per-cycle checker on the fetch response

`timescale 1ns/10ps

module icache_tb import icache_pkg::*; ();

	localparam logic [31:0] ROM_BASE = 32'h0000_1000;
	// Bus addresses in this window answer with err
	localparam logic [31:0] FLT_BASE = 32'h0000_2000;
	// Far above 31 fetches of at most 30 cycles each
	localparam int TIMEOUT_CYCLES = 20000;
	localparam int FETCH_LIMIT = 200;

	logic clk;
	logic rst;
	logic [31:0] fetch_addr;
	fetch_rsp_t fetch_rsp;
	logic inv;
	logic [31:0] inv_addr;
	bus_req_t bus;
	// Bus slave outputs start idle
	logic ack = 1'b0;
	logic err = 1'b0;
	logic [31:0] dat = '0;
	logic cfg_we;
	logic [1:0] cfg_addr;
	logic [31:0] cfg_wdata;
	logic [31:0] cfg_rdata;

	logic [31:0] rsp_addr;
	logic [31:0] lfsr;
	logic beat_open = 1'b0;
	int wait_left = 0;
	int bus_cycles = 0;
	int cycles = 0;
	int value_errs = 0;
	int other_errs = 0;

	tb_clkgen #(.PERIOD(40), .RESET_CYCLES(10)) u_clkgen (.clk_o(clk), .rst_o(rst));

	icache_top #(
		.ADDR_W(32),
		.LINES(16),
		.ROM_BASE(ROM_BASE)
	) dut (
		.clk(clk),
		.rst_i(rst),
		.fetch_addr_i(fetch_addr),
		.fetch_rsp_o(fetch_rsp),
		.inv_i(inv),
		.inv_addr_i(inv_addr),
		.bus_o(bus),
		.ack_i(ack),
		.err_i(err),
		.dat_i(dat),
		.cfg_we_i(cfg_we),
		.cfg_addr_i(cfg_addr),
		.cfg_wdata_i(cfg_wdata),
		.cfg_rdata_o(cfg_rdata)
	);

	bind icache_top icache_assertions u_assertions (
		.clk(clk),
		.rst_i(rst_i),
		.bus_i(bus_o),
		.ack_i(ack_i),
		.err_i(err_i),
		.burst_en_i(burst_en)
	);

	// ========================================
	// Reference model
	// ========================================
	function automatic logic [31:0] mem_word(input logic [31:0] addr);
		return addr * 32'd3 + 32'd5;
	endfunction

	function automatic logic in_fault_window(input logic [31:0] addr);
		return (addr >= FLT_BASE) && (addr < FLT_BASE + 32'd64);
	endfunction

	function automatic logic in_rom_window(input logic [31:0] addr);
		return (addr >= ROM_BASE) && (addr < ROM_BASE + 32'd64);
	endfunction

	function automatic logic [31:0] expected_word(input logic [31:0] addr);
		if (in_fault_window(addr))
			return NOP_WORD;
		if (in_rom_window(addr))
			return 32'h1300_0000 + (addr - ROM_BASE);
		return mem_word(addr);
	endfunction

	function automatic fault_t expected_fault(input logic [31:0] addr);
		return in_fault_window(addr) ? FLT_BUS : FLT_NONE;
	endfunction

	// Galois LFSR with 32-bit taps
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		if (s[0])
			return (s >> 1) ^ 32'h8020_0003;
		return s >> 1;
	endfunction

	// One LFSR step per bit taken
	task automatic random_bits(input int n, output int val);
		val = 0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			val = (val << 1) | int'(lfsr[0]);
		end
	endtask

	// ========================================
	// Bus memory model
	// ========================================
	// Each beat waits 0 to 3 cycles and then gets ack or err for one cycle
	always begin
		@(posedge clk);
		#2;
		ack = 1'b0;
		err = 1'b0;
		dat = '0;
		if (!rst && bus.cyc && bus.stb) begin
			if (!beat_open) begin
				beat_open = 1'b1;
				random_bits(2, wait_left);
			end
			if (wait_left == 0) begin
				beat_open = 1'b0;
				if (in_fault_window(bus.adr)) begin
					err = 1'b1;
				end else begin
					ack = 1'b1;
					dat = mem_word(bus.adr);
				end
			end else begin
				wait_left = wait_left - 1;
			end
		end else begin
			beat_open = 1'b0;
		end
	end

	// Address the array looks up in the current cycle
	always @(posedge clk)
		rsp_addr <= fetch_addr;

	// Compare every ready response against the reference
	always @(negedge clk) begin
		if (!rst && fetch_rsp.rdy) begin
			if (fetch_rsp.word !== expected_word(rsp_addr)) begin
				value_errs++;
				$display("ERR %0t: word at %h is %h, expected %h", $time, rsp_addr,
					fetch_rsp.word, expected_word(rsp_addr));
			end
			if (fetch_rsp.fault !== expected_fault(rsp_addr)) begin
				value_errs++;
				$display("ERR %0t: fault at %h is %0d, expected %0d", $time, rsp_addr,
					fetch_rsp.fault, expected_fault(rsp_addr));
			end
		end
	end

	always @(negedge clk) begin
		if (!rst && bus.cyc)
			bus_cycles++;
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Run stopped at the cycle limit of %0d cycles", TIMEOUT_CYCLES);
			$display("Something failed");
			$finish;
		end
	end

	// ========================================
	// Stimulus tasks
	// ========================================
	// Holds the address until rdy and counts the cycles spent waiting
	task automatic fetch(input logic [31:0] addr, output int waits);
		@(posedge clk);
		#2;
		fetch_addr = addr;
		@(posedge clk);
		waits = 0;
		@(negedge clk);
		while (!fetch_rsp.rdy && waits < FETCH_LIMIT) begin
			waits++;
			@(negedge clk);
		end
		if (!fetch_rsp.rdy) begin
			other_errs++;
			$display("Fetch of address %h never returned a ready word", addr);
		end
	endtask

	task automatic read_reg(input logic [1:0] addr, output logic [31:0] val);
		@(posedge clk);
		#2;
		cfg_addr = addr;
		@(negedge clk);
		val = cfg_rdata;
	endtask

	task automatic write_reg(input logic [1:0] addr, input logic [31:0] val);
		@(posedge clk);
		#2;
		cfg_we = 1'b1;
		cfg_addr = addr;
		cfg_wdata = val;
		@(posedge clk);
		#2;
		cfg_we = 1'b0;
	endtask

	task automatic invalidate(input logic [31:0] addr);
		@(posedge clk);
		#2;
		inv = 1'b1;
		inv_addr = addr;
		@(posedge clk);
		#2;
		inv = 1'b0;
	endtask

	initial begin
		logic [31:0] f0;
		logic [31:0] f1;
		logic [31:0] g0;
		logic [31:0] g1;
		logic [31:0] ctrl;
		int waits;
		int bc;
		fetch_addr = '0;
		inv = 1'b0;
		inv_addr = '0;
		cfg_we = 1'b0;
		cfg_addr = CFG_CTRL;
		cfg_wdata = '0;
		lfsr = 32'd89434;
		wait (rst === 1'b0);
		// Let the line 0 fill that follows reset finish
		fetch(32'h0, waits);

		// Cold misses over the bus in burst mode
		read_reg(CFG_FILLS, f0);
		for (int i = 0; i < 8; i++)
			fetch(32'h0000_0100 + 32'(i * 5), waits);
		read_reg(CFG_FILLS, f1);
		if (f1 !== f0 + 32'd8) begin
			value_errs++;
			$display("ERR %0t: fill count %0d, expected %0d", $time, f1, f0 + 32'd8);
		end

		// ROM window fetches must not touch the bus
		for (int i = 0; i < 7; i++) begin
			bc = bus_cycles;
			fetch(ROM_BASE + 32'(i * 10), waits);
			if (bus_cycles != bc) begin
				value_errs++;
				$display("ERR %0t: %0d bus cycles during ROM fill", $time, bus_cycles - bc);
			end
		end

		// Hits in a cached line
		fetch(32'h0000_0300, waits);
		read_reg(CFG_FILLS, f0);
		fetch(32'h0000_0302, waits);
		if (waits != 0) begin
			value_errs++;
			$display("ERR %0t: cached fetch took %0d wait cycles", $time, waits);
		end
		fetch(32'h0000_0300, waits);
		if (waits != 0) begin
			value_errs++;
			$display("ERR %0t: repeated fetch took %0d wait cycles", $time, waits);
		end
		read_reg(CFG_FILLS, f1);
		if (f1 !== f0) begin
			value_errs++;
			$display("ERR %0t: fill count moved from %0d to %0d on hits", $time, f0, f1);
		end

		// Second fetch in the fault window hits the faulted line
		read_reg(CFG_FAULTS, g0);
		fetch(FLT_BASE + 32'd1, waits);
		fetch(FLT_BASE + 32'd2, waits);
		fetch(FLT_BASE + 32'd18, waits);
		read_reg(CFG_FAULTS, g1);
		if (g1 !== g0 + 32'd2) begin
			value_errs++;
			$display("ERR %0t: fault count %0d, expected %0d", $time, g1, g0 + 32'd2);
		end

		// Bursts off so beats are spaced by strobe gaps
		write_reg(CFG_CTRL, 32'd0);
		read_reg(CFG_CTRL, ctrl);
		if (ctrl !== 32'd0) begin
			value_errs++;
			$display("ERR %0t: control reads %h after clearing burst enable", $time, ctrl);
		end
		read_reg(CFG_FILLS, f0);
		for (int i = 0; i < 6; i++)
			fetch(32'h0000_0500 + 32'(i * 9), waits);
		read_reg(CFG_FILLS, f1);
		if (f1 !== f0 + 32'd6) begin
			value_errs++;
			$display("ERR %0t: fill count %0d, expected %0d", $time, f1, f0 + 32'd6);
		end
		write_reg(CFG_CTRL, 32'd1);

		// Invalidate a cached line and fetch it again
		fetch(32'h0000_0600, waits);
		fetch(32'h0000_0614, waits);
		read_reg(CFG_FILLS, f0);
		invalidate(32'h0000_0602);
		repeat (3) @(posedge clk);
		fetch(32'h0000_0601, waits);
		if (waits == 0) begin
			value_errs++;
			$display("ERR %0t: fetch after invalidate was a hit", $time);
		end
		read_reg(CFG_FILLS, f1);
		if (f1 !== f0 + 32'd1) begin
			value_errs++;
			$display("ERR %0t: fill count %0d, expected %0d", $time, f1, f0 + 32'd1);
		end

		$display("Run done with %0d value errors and %0d other errors", value_errs, other_errs);
		if (value_errs == 0 && other_errs == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

//--- test/icache_assertions.sv
// Bus protocol and refill checks for the instruction cache
// Bound onto the cache top level, looks at the bus master outputs

`timescale 1ns/10ps

module icache_assertions import icache_pkg::*; (
	input logic clk,
	input logic rst_i,
	input bus_req_t bus_i,
	input logic ack_i,
	input logic err_i,
	input logic burst_en_i
);

	// Strobe only inside a cycle
	stb_in_cyc: assert property (@(posedge clk) disable iff (rst_i)
		bus_i.stb |-> bus_i.cyc)
		else $error("stb high outside a bus cycle");

	// Address held while the slave stalls
	adr_hold: assert property (@(posedge clk) disable iff (rst_i)
		(bus_i.stb && !ack_i && !err_i) |=> $stable(bus_i.adr))
		else $error("adr changed during a stalled beat");

	// Bus idle right after reset
	cyc_after_rst: assert property (@(posedge clk)
		$fell(rst_i) |-> !bus_i.cyc)
		else $error("cyc high after reset");

	// Last word of the line carries the end tag
	cti_tag: assert property (@(posedge clk) disable iff (rst_i)
		bus_i.stb |-> (bus_i.cti == ((bus_i.adr[OFF_W-1:0] == OFF_W'(BEATS-1)) ?
			CTI_END : CTI_INC)))
		else $error("cti does not match the beat position");

	// Bursts off means one idle strobe cycle between beats
	beat_gap: assert property (@(posedge clk) disable iff (rst_i)
		(!burst_en_i && bus_i.stb && ack_i && bus_i.cti == CTI_INC) |=> !bus_i.stb)
		else $error("no strobe gap between beats with bursts off");

	beat_back_to_back: assert property (@(posedge clk) disable iff (rst_i)
		(burst_en_i && bus_i.stb && ack_i && bus_i.cti == CTI_INC) |=> bus_i.stb)
		else $error("strobe dropped inside a burst");

endmodule

//--- test/tb_clkgen.sv
// Testbench clock and reset source
// Free-running clock, reset held high for a set number of cycles

`timescale 1ns/10ps

module tb_clkgen #(
	parameter int PERIOD = 40,
	parameter int RESET_CYCLES = 10
) (
	output logic clk_o,
	output logic rst_o
);

	initial begin
		clk_o = 1'b0;
		forever #(PERIOD / 2) clk_o = ~clk_o;
	end

	// Release lands 2 ns after an edge, like the other inputs
	initial begin
		rst_o = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk_o);
		#2;
		rst_o = 1'b0;
	end

endmodule

//--- hw/icache_top.sv
// Instruction cache refill subsystem top level
// Connects the L1 array, refill controller, config registers and boot ROM

`timescale 1ns/10ps

module icache_top import icache_pkg::*; #(
	parameter int ADDR_W = 32,
	parameter int LINES = 16,
	parameter logic [ADDR_W-1:0] ROM_BASE = 'h0000_1000
) (
	input logic clk,
	input logic rst_i,
	input logic [ADDR_W-1:0] fetch_addr_i,
	output fetch_rsp_t fetch_rsp_o,
	input logic inv_i,
	input logic [ADDR_W-1:0] inv_addr_i,
	output bus_req_t bus_o,
	input logic ack_i,
	input logic err_i,
	input logic [WORD_W-1:0] dat_i,
	input logic cfg_we_i,
	input logic [1:0] cfg_addr_i,
	input logic [WORD_W-1:0] cfg_wdata_i,
	output logic [WORD_W-1:0] cfg_rdata_o
);

	localparam int LINE_W = ADDR_W - OFF_W;

	// Array side
	logic hit;
	logic [LINE_W-1:0] miss_addr;
	logic wr;
	logic [LINE_W-1:0] wr_addr;
	line_t wr_line;
	fault_t wr_fault;
	logic inv;
	logic [LINE_W-1:0] inv_line_addr;

	// ROM side
	logic rom_rd;
	logic [ROM_AW-1:0] rom_addr;
	line_t rom_line;

	// Register block side
	logic burst_en;
	logic fill_done;
	logic fault;

	icache_array #(
		.ADDR_W(ADDR_W),
		.LINES(LINES)
	) u_array (
		.clk(clk),
		.rst_i(rst_i),
		.fetch_addr_i(fetch_addr_i),
		.fetch_rsp_o(fetch_rsp_o),
		.hit_o(hit),
		.miss_addr_o(miss_addr),
		.wr_i(wr),
		.wr_addr_i(wr_addr),
		.wr_line_i(wr_line),
		.wr_fault_i(wr_fault),
		.inv_i(inv),
		.inv_line_addr_i(inv_line_addr)
	);

	icache_refill_ctrl #(
		.ADDR_W(ADDR_W),
		.ROM_BASE(ROM_BASE)
	) u_ctrl (
		.clk(clk),
		.rst_i(rst_i),
		.hit_i(hit),
		.miss_addr_i(miss_addr),
		.inv_i(inv_i),
		.inv_addr_i(inv_addr_i),
		.burst_en_i(burst_en),
		.wr_o(wr),
		.wr_addr_o(wr_addr),
		.wr_line_o(wr_line),
		.wr_fault_o(wr_fault),
		.inv_o(inv),
		.inv_line_addr_o(inv_line_addr),
		.rom_rd_o(rom_rd),
		.rom_addr_o(rom_addr),
		.rom_line_i(rom_line),
		.bus_o(bus_o),
		.ack_i(ack_i),
		.err_i(err_i),
		.dat_i(dat_i),
		.fill_done_o(fill_done),
		.fault_o(fault)
	);

	icache_cfg_regs u_regs (
		.clk(clk),
		.rst_i(rst_i),
		.cfg_we_i(cfg_we_i),
		.cfg_addr_i(cfg_addr_i),
		.cfg_wdata_i(cfg_wdata_i),
		.cfg_rdata_o(cfg_rdata_o),
		.burst_en_o(burst_en),
		.fill_done_i(fill_done),
		.fault_i(fault)
	);

	boot_rom u_rom (
		.clk(clk),
		.rd_i(rom_rd),
		.addr_i(rom_addr),
		.line_o(rom_line)
	);

endmodule

//--- hw/icache/icache_cfg_regs.sv
// Instruction cache configuration registers
// Burst enable control bit plus saturating line-fill and fault counters

`timescale 1ns/10ps

module icache_cfg_regs import icache_pkg::*; (
	input logic clk,
	input logic rst_i,
	input logic cfg_we_i,
	input logic [1:0] cfg_addr_i,
	input logic [WORD_W-1:0] cfg_wdata_i,
	output logic [WORD_W-1:0] cfg_rdata_o,
	output logic burst_en_o,
	input logic fill_done_i,
	input logic fault_i
);

	logic [CNT_W-1:0] fills_q;
	logic [CNT_W-1:0] faults_q;

	// Count up, stick at all ones
	function automatic logic [CNT_W-1:0] sat_inc(input logic [CNT_W-1:0] cnt);
		return (cnt == '1) ? cnt : cnt + 1'b1;
	endfunction

	always_ff @(posedge clk) begin
		if (rst_i) begin
			burst_en_o <= 1'b1;
			fills_q <= '0;
			faults_q <= '0;
		end else begin
			if (cfg_we_i && cfg_addr_i == CFG_CTRL)
				burst_en_o <= cfg_wdata_i[0];
			// Any write clears a counter
			if (cfg_we_i && cfg_addr_i == CFG_FILLS)
				fills_q <= '0;
			else if (fill_done_i)
				fills_q <= sat_inc(fills_q);
			if (cfg_we_i && cfg_addr_i == CFG_FAULTS)
				faults_q <= '0;
			else if (fault_i)
				faults_q <= sat_inc(faults_q);
		end
	end

	always_comb begin
		case (cfg_addr_i)
		CFG_CTRL: cfg_rdata_o = WORD_W'(burst_en_o);
		CFG_FILLS: cfg_rdata_o = WORD_W'(fills_q);
		CFG_FAULTS: cfg_rdata_o = WORD_W'(faults_q);
		default: cfg_rdata_o = '0;
		endcase
	end

endmodule

//--- hw/icache/icache_refill_ctrl.sv
// Instruction cache refill controller
// Serves misses from the boot ROM or by a four-beat bus read, fills faulted
// lines with NOPs, and applies queued single-line invalidates when idle

`timescale 1ns/10ps

module icache_refill_ctrl import icache_pkg::*; #(
	parameter int ADDR_W = 32,
	parameter logic [ADDR_W-1:0] ROM_BASE = 'h0000_1000
) (
	input logic clk,
	input logic rst_i,
	input logic hit_i,
	input logic [ADDR_W-OFF_W-1:0] miss_addr_i,
	input logic inv_i,
	input logic [ADDR_W-1:0] inv_addr_i,
	input logic burst_en_i,
	output logic wr_o,
	output logic [ADDR_W-OFF_W-1:0] wr_addr_o,
	output line_t wr_line_o,
	output fault_t wr_fault_o,
	output logic inv_o,
	output logic [ADDR_W-OFF_W-1:0] inv_line_addr_o,
	output logic rom_rd_o,
	output logic [ROM_AW-1:0] rom_addr_o,
	input line_t rom_line_i,
	output bus_req_t bus_o,
	input logic ack_i,
	input logic err_i,
	input logic [WORD_W-1:0] dat_i,
	output logic fill_done_o,
	output logic fault_o
);

	localparam int LINE_W = ADDR_W - OFF_W;
	localparam logic [LINE_W-1:0] ROM_LINE_BASE = ROM_BASE[ADDR_W-1:OFF_W];

	typedef enum logic [2:0] {
		S_IDLE,
		S_ROM,
		S_BEAT,
		S_GAP,
		S_WRITE
	} state_t;

	state_t state_q;

	// Line being assembled and where it goes
	line_t line_q;
	fault_t fault_q;
	logic [LINE_W-1:0] fill_adr_q;
	logic [OFF_W-1:0] beat_q;

	// Pending invalidate
	logic inv_pend_q;
	logic [LINE_W-1:0] inv_adr_q;

	// ROM window check on the missing line
	logic [LINE_W-1:0] rom_off;
	logic in_rom;
	logic start_fill;

	assign rom_off = miss_addr_i - ROM_LINE_BASE;
	assign in_rom = rom_off < LINE_W'(ROM_LINES);

	// An invalidate always goes before a new miss
	assign inv_o = (state_q == S_IDLE) && inv_pend_q;
	assign inv_line_addr_o = inv_adr_q;
	assign start_fill = (state_q == S_IDLE) && !inv_pend_q && !hit_i;

	assign rom_rd_o = start_fill && in_rom;
	assign rom_addr_o = rom_off[ROM_AW-1:0];

	assign wr_o = (state_q == S_WRITE);
	assign wr_addr_o = fill_adr_q;
	assign wr_line_o = line_q;
	assign wr_fault_o = fault_q;

	// Invalidate capture, a new request overrides the one being applied
	always_ff @(posedge clk) begin
		if (rst_i) begin
			inv_pend_q <= 1'b0;
		end else if (inv_i) begin
			inv_pend_q <= 1'b1;
		end else if (inv_o) begin
			inv_pend_q <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (inv_i)
			inv_adr_q <= inv_addr_i[ADDR_W-1:OFF_W];
	end

	// ========================================
	// Refill state machine
	// ========================================
	always_ff @(posedge clk) begin
		if (rst_i) begin
			state_q <= S_IDLE;
			bus_o <= '0;
		end else begin
			case (state_q)
			S_IDLE: begin
				if (start_fill) begin
					fill_adr_q <= miss_addr_i;
					fault_q <= FLT_NONE;
					beat_q <= '0;
					if (in_rom) begin
						state_q <= S_ROM;
					end else begin
						bus_o.cyc <= 1'b1;
						bus_o.stb <= 1'b1;
						bus_o.cti <= CTI_INC;
						bus_o.adr <= WORD_W'({miss_addr_i, {OFF_W{1'b0}}});
						state_q <= S_BEAT;
					end
				end
			end
			// ROM answers one cycle after the read strobe
			S_ROM: begin
				line_q <= rom_line_i;
				state_q <= S_WRITE;
			end
			S_BEAT: begin
				if (err_i) begin
					// Whole line becomes NOPs, the fetch sees the fault code
					bus_o <= '0;
					line_q <= {BEATS{NOP_WORD}};
					fault_q <= FLT_BUS;
					state_q <= S_WRITE;
				end else if (ack_i) begin
					line_q[beat_q] <= dat_i;
					if (beat_q == OFF_W'(BEATS-1)) begin
						bus_o <= '0;
						state_q <= S_WRITE;
					end else begin
						beat_q <= beat_q + 1'b1;
						bus_o.adr <= bus_o.adr + 1'b1;
						// Tag the final beat
						bus_o.cti <= (beat_q == OFF_W'(BEATS-2)) ? CTI_END : CTI_INC;
						if (!burst_en_i) begin
							bus_o.stb <= 1'b0;
							state_q <= S_GAP;
						end
					end
				end
			end
			// Strobe low for one cycle between beats
			S_GAP: begin
				bus_o.stb <= 1'b1;
				state_q <= S_BEAT;
			end
			S_WRITE: begin
				state_q <= S_IDLE;
			end
			default: begin
				state_q <= S_IDLE;
			end
			endcase
		end
	end

	// Fill and fault pulses, one cycle after the array write
	always_ff @(posedge clk) begin
		if (rst_i) begin
			fill_done_o <= 1'b0;
			fault_o <= 1'b0;
		end else begin
			fill_done_o <= wr_o;
			fault_o <= wr_o && (fault_q == FLT_BUS);
		end
	end

endmodule

//--- hw/icache/icache_array.sv
// Direct-mapped L1 instruction array
// Holds valid, tag, fault code and line data per entry, looks up the
// registered fetch address and takes line writes and single-line invalidates

`timescale 1ns/10ps

module icache_array import icache_pkg::*; #(
	parameter int ADDR_W = 32,
	parameter int LINES = 16
) (
	input logic clk,
	input logic rst_i,
	input logic [ADDR_W-1:0] fetch_addr_i,
	output fetch_rsp_t fetch_rsp_o,
	output logic hit_o,
	output logic [ADDR_W-OFF_W-1:0] miss_addr_o,
	input logic wr_i,
	input logic [ADDR_W-OFF_W-1:0] wr_addr_i,
	input line_t wr_line_i,
	input fault_t wr_fault_i,
	input logic inv_i,
	input logic [ADDR_W-OFF_W-1:0] inv_line_addr_i
);

	localparam int LINE_W = ADDR_W - OFF_W;
	localparam int IDX_W = $clog2(LINES);
	localparam int TAG_W = LINE_W - IDX_W;

	logic [LINES-1:0] valid_q;
	logic [TAG_W-1:0] tag_mem [LINES];
	fault_t fault_mem [LINES];
	line_t data_mem [LINES];

	// Registered fetch address, split into tag, index and word offset
	logic [ADDR_W-1:0] addr_q;
	logic [LINE_W-1:0] line_addr;
	logic [IDX_W-1:0] idx;
	logic [TAG_W-1:0] tag;
	logic [OFF_W-1:0] off;

	always_ff @(posedge clk) begin
		if (rst_i) begin
			addr_q <= '0;
		end else begin
			addr_q <= fetch_addr_i;
		end
	end

	assign line_addr = addr_q[ADDR_W-1:OFF_W];
	assign idx = line_addr[IDX_W-1:0];
	assign tag = line_addr[LINE_W-1:IDX_W];
	assign off = addr_q[OFF_W-1:0];

	// Valid bits, all lines invalid after reset
	always_ff @(posedge clk) begin
		if (rst_i) begin
			valid_q <= '0;
		end else begin
			if (wr_i)
				valid_q[wr_addr_i[IDX_W-1:0]] <= 1'b1;
			if (inv_i)
				valid_q[inv_line_addr_i[IDX_W-1:0]] <= 1'b0;
		end
	end

	// Tag, fault and data storage
	always_ff @(posedge clk) begin
		if (wr_i) begin
			tag_mem[wr_addr_i[IDX_W-1:0]] <= wr_addr_i[LINE_W-1:IDX_W];
			fault_mem[wr_addr_i[IDX_W-1:0]] <= wr_fault_i;
			data_mem[wr_addr_i[IDX_W-1:0]] <= wr_line_i;
		end
	end

	// Lookup, a write shows up here on the cycle after it
	assign hit_o = valid_q[idx] && (tag_mem[idx] == tag);
	assign miss_addr_o = line_addr;

	assign fetch_rsp_o.rdy = hit_o;
	assign fetch_rsp_o.word = data_mem[idx][off];
	assign fetch_rsp_o.fault = fault_mem[idx];

endmodule

//--- hw/boot_rom.sv
// Boot ROM, one full cache line per read
// Word n of the ROM holds 32'h1300_0000 plus n, registered output

`timescale 1ns/10ps

module boot_rom import icache_pkg::*; (
	input logic clk,
	input logic rd_i,
	input logic [ROM_AW-1:0] addr_i,
	output line_t line_o
);

	// Highest word first, so beat 0 lands in the low bits
	always_ff @(posedge clk) begin
		if (rd_i) begin
			case (addr_i)
			4'h0: line_o <= {32'h1300_0003, 32'h1300_0002, 32'h1300_0001, 32'h1300_0000};
			4'h1: line_o <= {32'h1300_0007, 32'h1300_0006, 32'h1300_0005, 32'h1300_0004};
			4'h2: line_o <= {32'h1300_000b, 32'h1300_000a, 32'h1300_0009, 32'h1300_0008};
			4'h3: line_o <= {32'h1300_000f, 32'h1300_000e, 32'h1300_000d, 32'h1300_000c};
			4'h4: line_o <= {32'h1300_0013, 32'h1300_0012, 32'h1300_0011, 32'h1300_0010};
			4'h5: line_o <= {32'h1300_0017, 32'h1300_0016, 32'h1300_0015, 32'h1300_0014};
			4'h6: line_o <= {32'h1300_001b, 32'h1300_001a, 32'h1300_0019, 32'h1300_0018};
			4'h7: line_o <= {32'h1300_001f, 32'h1300_001e, 32'h1300_001d, 32'h1300_001c};
			4'h8: line_o <= {32'h1300_0023, 32'h1300_0022, 32'h1300_0021, 32'h1300_0020};
			4'h9: line_o <= {32'h1300_0027, 32'h1300_0026, 32'h1300_0025, 32'h1300_0024};
			4'ha: line_o <= {32'h1300_002b, 32'h1300_002a, 32'h1300_0029, 32'h1300_0028};
			4'hb: line_o <= {32'h1300_002f, 32'h1300_002e, 32'h1300_002d, 32'h1300_002c};
			4'hc: line_o <= {32'h1300_0033, 32'h1300_0032, 32'h1300_0031, 32'h1300_0030};
			4'hd: line_o <= {32'h1300_0037, 32'h1300_0036, 32'h1300_0035, 32'h1300_0034};
			4'he: line_o <= {32'h1300_003b, 32'h1300_003a, 32'h1300_0039, 32'h1300_0038};
			default: line_o <= {32'h1300_003f, 32'h1300_003e, 32'h1300_003d, 32'h1300_003c};
			endcase
		end
	end

endmodule

//--- common/icache_pkg.sv
// Instruction cache shared definitions
// Word and line layout, fault codes, bus request and fetch response types
// and the register map of the cache configuration block

package icache_pkg;

	// ========================================
	// Word and line layout
	// ========================================
	localparam int WORD_W = 32;
	localparam int BEATS = 4;
	// Word offset bits inside a line
	localparam int OFF_W = $clog2(BEATS);

	// Beat 0 sits in the low word
	typedef logic [BEATS-1:0][WORD_W-1:0] line_t;

	// Boot ROM window, counted in lines
	localparam int ROM_LINES = 16;
	localparam int ROM_AW = $clog2(ROM_LINES);

	// ========================================
	// Fault codes
	// ========================================
	typedef logic [1:0] fault_t;

	localparam fault_t FLT_NONE = 2'd0;
	localparam fault_t FLT_BUS = 2'd1;

	// Filler for lines whose refill saw a bus error
	localparam logic [WORD_W-1:0] NOP_WORD = 32'h0000_0013;

	// ========================================
	// Bus and fetch types
	// ========================================
	// Cycle type tags
	localparam logic [2:0] CTI_INC = 3'b001;
	localparam logic [2:0] CTI_END = 3'b111;

	typedef struct packed {
		logic cyc;
		logic stb;
		logic [2:0] cti;
		logic [WORD_W-1:0] adr;
	} bus_req_t;

	typedef struct packed {
		logic rdy;
		logic [WORD_W-1:0] word;
		fault_t fault;
	} fetch_rsp_t;

	// Config register map
	localparam int CNT_W = 16;
	localparam logic [1:0] CFG_CTRL = 2'd0;
	localparam logic [1:0] CFG_FILLS = 2'd1;
	localparam logic [1:0] CFG_FAULTS = 2'd2;

endpackage
